//--- vdp_pkg.sv
package vdp_pkg;

  // --------------------
  // Bus and memory sizes
  // --------------------
  localparam int DATA_W     = 8;
  localparam int VRAM_AW    = 14;
  localparam int VRAM_DEPTH = 16384;  // 16 KB, 1 << VRAM_AW

  localparam logic [DATA_W-1:0] CTRL_PORT_ADDR = 8'hBF;  // Everything else is data port

  // Mode registers
  localparam int REG_COUNT = 10;
  localparam int REG_IDX_W = 4;

  // --------------------
  // Command encoding
  // --------------------
  // Top two bits of the second command byte
  typedef enum logic [1:0] {
    OP_VRAM_READ  = 2'd0,
    OP_VRAM_WRITE = 2'd1,
    OP_REG_WRITE  = 2'd2,
    OP_CRAM_WRITE = 2'd3
  } vdp_op_e;

  // One decoded bus access, valid for two cycles
  typedef struct packed {
    logic rd;
    logic wr;
    logic ctrl;  // 1 = control port
    logic go;
  } bus_acc_t;

  typedef struct packed {
    logic               we;
    logic [VRAM_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
  } vram_req_t;

  typedef logic [REG_COUNT-1:0][DATA_W-1:0] reg_array_t;

  // FSM states, kept here so waveforms show names
  typedef enum logic [2:0] {
    DEC_IDLE,
    DEC_RD0,
    DEC_RD1,
    DEC_WR0,
    DEC_WR1
  } dec_state_e;

  typedef enum logic [3:0] {
    CMD_LOAD_LO,
    CMD_LOAD_HI,
    CMD_HI_WAIT,
    CMD_DECODE,
    CMD_REG_WRITE,
    CMD_READ_DATA,
    CMD_WRITE_DATA,
    CMD_CRAM_DATA
  } cmd_state_e;

endpackage

//--- vdp_port_decoder.sv
`timescale 1ns/1ps

module vdp_port_decoder import vdp_pkg::*; (
  input  logic              clk,
  input  logic              rst_L,
  input  logic [DATA_W-1:0] addr,
  input  logic              iorq_L,
  input  logic              rd_L,
  input  logic              wr_L,
  output bus_acc_t          acc
);

  dec_state_e state, state_n;
  logic       ctrl_q;   // Port select captured at detection
  logic       wr_req;
  logic       rd_req;

  assign wr_req = !iorq_L && !wr_L;
  assign rd_req = !iorq_L && !rd_L;

  // --------------------
  // Strobe FSM
  // --------------------
  always_comb begin
    state_n = state;
    case (state)
      DEC_IDLE: begin
        if (wr_req) state_n = DEC_WR0;  // Write wins if both are low
        else if (rd_req) state_n = DEC_RD0;
      end
      DEC_RD0: state_n = DEC_RD1;
      DEC_WR0: state_n = DEC_WR1;
      default: state_n = DEC_IDLE;    // RD1, WR1 always drop back to idle
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state  <= DEC_IDLE;
      ctrl_q <= 1'b0;
    end else begin
      state <= state_n;
      if (state == DEC_IDLE && (wr_req || rd_req))
        ctrl_q <= (addr == CTRL_PORT_ADDR);
    end
  end

  assign acc.rd   = (state == DEC_RD0) || (state == DEC_RD1);
  assign acc.wr   = (state == DEC_WR0) || (state == DEC_WR1);
  assign acc.ctrl = ctrl_q;
  assign acc.go   = acc.rd || acc.wr;

  rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_L)
    !(acc.rd && acc.wr));

  // Every access is exactly two cycles wide with a gap behind it
  two_cycle_strobe: assert property (@(posedge clk) disable iff (!rst_L)
    $rose(acc.go) |=> acc.go ##1 !acc.go);

endmodule

//--- vdp_cmd_ctrl.sv
`timescale 1ns/1ps

module vdp_cmd_ctrl import vdp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_L,
  input  bus_acc_t             acc,
  input  logic [DATA_W-1:0]    data_in,
  output vram_req_t            vram_req,
  output logic                 buf_load,
  output logic                 read_mode,
  output logic                 reg_we,
  output logic [REG_IDX_W-1:0] reg_idx,
  output logic [DATA_W-1:0]    reg_wdata
);

  cmd_state_e         state, state_n;
  vdp_op_e            op;
  logic [DATA_W-1:0]  cmd_lo;
  logic [DATA_W-1:0]  cmd_hi;
  logic [DATA_W-1:0]  wdata_q;
  logic [VRAM_AW-1:0] addr_q;
  logic               go_q;
  logic               acc_first;   // First strobe cycle
  logic               acc_end;     // Cycle right after the strobe
  logic               ctrl_wr, data_wr, data_rd;
  logic               in_data;
  logic               data_pend;
  logic               data_step;
  logic               rd_chg;
  logic               chg_q;

  assign op        = vdp_op_e'(cmd_hi[7:6]);
  assign acc_first = acc.go && !go_q;
  assign acc_end   = go_q && !acc.go;
  assign ctrl_wr   = acc_first && acc.wr && acc.ctrl;
  assign data_wr   = acc_first && acc.wr && !acc.ctrl;
  assign data_rd   = acc_first && acc.rd && !acc.ctrl;
  assign in_data   = (state == CMD_READ_DATA) || (state == CMD_WRITE_DATA) ||
                     (state == CMD_CRAM_DATA);
  assign data_step = acc_end && data_pend;

  // --------------------
  // Command FSM
  // --------------------
  always_comb begin
    state_n = state;
    case (state)
      CMD_LOAD_LO: if (ctrl_wr) state_n = CMD_LOAD_HI;
      CMD_LOAD_HI: if (ctrl_wr) state_n = CMD_HI_WAIT;
      CMD_HI_WAIT: state_n = CMD_DECODE;  // Second strobe cycle of the high byte
      CMD_DECODE: begin
        case (op)
          OP_VRAM_READ:  state_n = CMD_READ_DATA;
          OP_VRAM_WRITE: state_n = CMD_WRITE_DATA;
          OP_REG_WRITE:  state_n = CMD_REG_WRITE;
          default:       state_n = CMD_CRAM_DATA;
        endcase
      end
      CMD_REG_WRITE: state_n = CMD_LOAD_LO;
      CMD_READ_DATA, CMD_WRITE_DATA, CMD_CRAM_DATA: begin
        if (ctrl_wr) state_n = CMD_LOAD_HI;  // New command, this byte is its low half
      end
      default: state_n = CMD_LOAD_LO;
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state     <= CMD_LOAD_LO;
      go_q      <= 1'b0;
      data_pend <= 1'b0;
      addr_q    <= '0;
      chg_q     <= 1'b0;
      buf_load  <= 1'b0;
    end else begin
      state <= state_n;
      go_q  <= acc.go;
      if (acc_end) data_pend <= 1'b0;
      else if (in_data && (state == CMD_READ_DATA ? data_rd : data_wr))
        data_pend <= 1'b1;
      // Address loads from the command or steps after a data access
      if (state == CMD_DECODE) addr_q <= {cmd_hi[VRAM_AW-DATA_W-1:0], cmd_lo};
      else if (data_step) addr_q <= addr_q + 1'b1;  // Wraps at 16383
      chg_q    <= rd_chg;
      buf_load <= chg_q;   // VRAM output is valid one cycle after the address
    end
  end

  // Command bytes and write data
  always_ff @(posedge clk) begin
    if (ctrl_wr && (state == CMD_LOAD_LO || in_data)) cmd_lo <= data_in;
    if (ctrl_wr && state == CMD_LOAD_HI) cmd_hi <= data_in;
    if (data_wr) wdata_q <= data_in;
  end

  assign rd_chg = (state == CMD_DECODE && op == OP_VRAM_READ) ||
                  (state == CMD_READ_DATA && data_step);

  assign vram_req.we    = data_step && (state == CMD_WRITE_DATA);
  assign vram_req.addr  = addr_q;
  assign vram_req.wdata = wdata_q;

  assign read_mode = (state == CMD_READ_DATA);
  assign reg_we    = (state == CMD_REG_WRITE);
  assign reg_idx   = cmd_hi[REG_IDX_W-1:0];
  assign reg_wdata = cmd_lo;  // CRAM data bytes never reach anything

  we_in_write_phase: assert property (@(posedge clk) disable iff (!rst_L)
    vram_req.we |-> state == CMD_WRITE_DATA && !acc.go && $past(acc.wr));

  reg_we_pulse: assert property (@(posedge clk) disable iff (!rst_L)
    reg_we |=> !reg_we);

endmodule

//--- vdp_vram.sv
`timescale 1ns/1ps

module vdp_vram import vdp_pkg::*; (
  input  logic              clk,
  input  vram_req_t         vram_req,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [0:VRAM_DEPTH-1];

  // Single port, read data is registered every cycle
  always_ff @(posedge clk) begin
    if (vram_req.we)
      mem[vram_req.addr] <= vram_req.wdata;
    rdata <= mem[vram_req.addr];  // Old data on a write cycle
  end

endmodule

//--- vdp_reg_file.sv
`timescale 1ns/1ps

module vdp_reg_file import vdp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 reg_we,
  input  logic [REG_IDX_W-1:0] reg_idx,
  input  logic [DATA_W-1:0]    reg_wdata,
  output reg_array_t           regs
);

  logic idx_ok;

  // Indexes 10..15 are not implemented
  assign idx_ok = reg_idx < REG_IDX_W'(REG_COUNT);

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      regs <= '0;
    end else if (reg_we && idx_ok) begin
      regs[reg_idx] <= reg_wdata;
    end
  end

endmodule

//--- vdp_read_port.sv
`timescale 1ns/1ps

module vdp_read_port import vdp_pkg::*; (
  input  logic              clk,
  input  logic              rst_L,
  input  bus_acc_t          acc,
  input  logic              buf_load,
  input  logic              read_mode,
  input  logic [DATA_W-1:0] rdata,
  output logic [DATA_W-1:0] data_out,
  output logic              data_oe
);

  logic [DATA_W-1:0] rd_buf;  // Next byte for the CPU

  // --------------------
  // Read buffer
  // --------------------
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      rd_buf <= '0;
    end else if (buf_load) begin
      rd_buf <= rdata;
    end
  end

  // Only data-port reads in read mode are answered
  assign data_oe  = acc.rd && !acc.ctrl && read_mode;
  assign data_out = rd_buf;

  // Enable covers both strobe cycles and never a control access
  oe_data_port: assert property (@(posedge clk) disable iff (!rst_L)
    $rose(data_oe) |-> !acc.ctrl ##1 (data_oe && !acc.ctrl));

endmodule

//--- vdp_top.sv
`timescale 1ns/1ps

module vdp_top import vdp_pkg::*; (
  input  logic              clk,
  input  logic              rst_L,
  input  logic [DATA_W-1:0] addr,
  input  logic [DATA_W-1:0] data_in,
  input  logic              iorq_L,
  input  logic              rd_L,
  input  logic              wr_L,
  output logic [DATA_W-1:0] data_out,
  output logic              data_oe,
  output reg_array_t        vdp_regs
);

  bus_acc_t             acc;
  vram_req_t            vram_req;
  logic [DATA_W-1:0]    rdata;
  logic                 buf_load;
  logic                 read_mode;
  logic                 reg_we;
  logic [REG_IDX_W-1:0] reg_idx;
  logic [DATA_W-1:0]    reg_wdata;

  // --------------------
  // CPU side
  // --------------------
  vdp_port_decoder u_decoder (
    .clk    (clk),
    .rst_L  (rst_L),
    .addr   (addr),
    .iorq_L (iorq_L),
    .rd_L   (rd_L),
    .wr_L   (wr_L),
    .acc    (acc)
  );

  vdp_cmd_ctrl u_cmd_ctrl (
    .clk       (clk),
    .rst_L     (rst_L),
    .acc       (acc),
    .data_in   (data_in),
    .vram_req  (vram_req),
    .buf_load  (buf_load),
    .read_mode (read_mode),
    .reg_we    (reg_we),
    .reg_idx   (reg_idx),
    .reg_wdata (reg_wdata)
  );

  // --------------------
  // Storage and read back
  // --------------------
  vdp_vram u_vram (
    .clk      (clk),
    .vram_req (vram_req),
    .rdata    (rdata)
  );

  vdp_reg_file u_reg_file (
    .clk       (clk),
    .rst_L     (rst_L),
    .reg_we    (reg_we),
    .reg_idx   (reg_idx),
    .reg_wdata (reg_wdata),
    .regs      (vdp_regs)   // For a downstream display
  );

  vdp_read_port u_read_port (
    .clk       (clk),
    .rst_L     (rst_L),
    .acc       (acc),
    .buf_load  (buf_load),
    .read_mode (read_mode),
    .rdata     (rdata),
    .data_out  (data_out),
    .data_oe   (data_oe)
  );

endmodule

//--- tb_vdp_top.sv
`timescale 1ns/1ps

module tb_vdp_top import vdp_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam logic [7:0] DATA_PORT = 8'hBE;
  localparam int ACCESS_COUNT = 22 + 20 + 12 + 20 + 8;  // Accesses made by tests 2 to 6
  localparam int unsigned RAND_SEED = 32'hd777;

  logic        clk;
  logic        rst_L;
  logic [7:0]  addr;
  logic [7:0]  data_in;
  logic        iorq_L;
  logic        rd_L;
  logic        wr_L;
  logic [7:0]  data_out;
  logic        data_oe;
  reg_array_t  vdp_regs;

  reg_array_t  exp_regs;  // Mode registers as the CPU has written them
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;

  vdp_top u_dut (
    .clk      (clk),
    .rst_L    (rst_L),
    .addr     (addr),
    .data_in  (data_in),
    .iorq_L   (iorq_L),
    .rd_L     (rd_L),
    .wr_L     (wr_L),
    .data_out (data_out),
    .data_oe  (data_oe),
    .vdp_regs (vdp_regs)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog allows ten cycles per access plus slack for reset
  initial begin
    #(CLK_PERIOD * (ACCESS_COUNT * 10 + 200));
    $display("Timeout: run did not finish within %0d clock cycles", ACCESS_COUNT * 10 + 200);
    $display("Test FAILED");
    $finish;
  end

  // --------------------
  // Bus tasks
  // --------------------
  task automatic step_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                             input string msg);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("FAIL %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // Strobes go away after the detection edge while addr and data stay put
  task automatic start_access(input logic [7:0] port, input logic [7:0] wdata,
                              input logic is_wr);
    addr    = port;
    data_in = wdata;
    iorq_L  = 1'b0;
    wr_L    = !is_wr;
    rd_L    = is_wr;
    step_cycle();
    iorq_L = 1'b1;
    wr_L   = 1'b1;
    rd_L   = 1'b1;
  endtask

  task automatic bus_write(input logic [7:0] port, input logic [7:0] wdata);
    start_access(port, wdata, 1'b1);
    repeat (8) step_cycle();  // Two strobe cycles, then the idle gap
  endtask

  task automatic bus_read(input logic [7:0] port, input logic [7:0] expected);
    int oe_cycles;
    oe_cycles = 0;
    start_access(port, 8'h00, 1'b0);
    repeat (2) begin
      @(negedge clk);
      if (data_oe) begin
        oe_cycles++;
        check_equal(data_out, expected, $sformatf("data read at port %0h", port));
      end
      step_cycle();
    end
    if (oe_cycles == 0) begin
      err_cnt++;
      $display("Error at %0t ns: data_oe never rose on a read of port %0h", $time, port);
    end else begin
      check_equal(oe_cycles, 2, "data_oe width in cycles");
    end
    repeat (6) step_cycle();
  endtask

  task automatic bus_read_no_oe(input logic [7:0] port);
    logic seen;
    seen = 1'b0;
    start_access(port, 8'h00, 1'b0);
    repeat (2) begin
      @(negedge clk);
      seen = seen | data_oe;
      step_cycle();
    end
    check_equal(seen, 1'b0, $sformatf("data_oe on a read of port %0h", port));
    repeat (6) step_cycle();
  endtask

  task automatic send_vram_cmd(input vdp_op_e op, input logic [13:0] vaddr);
    bus_write(CTRL_PORT_ADDR, vaddr[7:0]);
    bus_write(CTRL_PORT_ADDR, {op, vaddr[13:8]});
  endtask

  task automatic send_reg_write(input logic [3:0] idx, input logic [7:0] value);
    bus_write(CTRL_PORT_ADDR, value);
    bus_write(CTRL_PORT_ADDR, {2'b10, 2'b00, idx});  // Opcode 2 in bits 7:6
    if (idx < 4'd10)
      exp_regs[idx] = value;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("[%0t ns] %s finished, %0d errors", $time, name, err_cnt - errs_before);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_state;
    int errs;
    errs = err_cnt;
    check_equal(vdp_regs, '0, "mode registers after reset");
    check_equal(data_oe, 1'b0, "data_oe after reset");
    report_test("reset_state", errs);
  endtask

  task automatic test_reg_writes;
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 10; i++) begin
      send_reg_write(4'(i), 8'($urandom));
      check_equal(vdp_regs, exp_regs, $sformatf("mode registers after index %0d", i));
    end
    send_reg_write(4'd12, 8'($urandom));
    check_equal(vdp_regs, exp_regs, "mode registers after index 12");
    report_test("reg_writes", errs);
  endtask

  // Sequential write from base, then the same bytes read back in order
  task automatic write_then_read(input string name, input logic [13:0] base, input int n);
    logic [7:0] wr_data [8];
    int errs;
    errs = err_cnt;
    send_vram_cmd(OP_VRAM_WRITE, base);
    for (int k = 0; k < n; k++) begin
      wr_data[k] = 8'($urandom);
      bus_write(DATA_PORT, wr_data[k]);
    end
    send_vram_cmd(OP_VRAM_READ, base);
    for (int k = 0; k < n; k++)
      bus_read(DATA_PORT, wr_data[k]);
    report_test(name, errs);
  endtask

  task automatic test_cram_write;
    logic [13:0] base;
    logic [7:0]  orig [4];
    int errs;
    errs = err_cnt;
    base = 14'($urandom);
    send_vram_cmd(OP_VRAM_WRITE, base);
    for (int k = 0; k < 4; k++) begin
      orig[k] = 8'($urandom);
      bus_write(DATA_PORT, orig[k]);
    end
    send_vram_cmd(OP_CRAM_WRITE, base);
    for (int k = 0; k < 4; k++)
      bus_write(DATA_PORT, ~orig[k]);  // Must not reach VRAM
    send_vram_cmd(OP_VRAM_READ, base);
    bus_read_no_oe(CTRL_PORT_ADDR);
    for (int k = 0; k < 4; k++)
      bus_read(DATA_PORT, orig[k]);
    bus_read_no_oe(CTRL_PORT_ADDR);
    report_test("cram_write", errs);
  endtask

  task automatic test_cmd_restart;
    logic [13:0] base;
    logic [7:0]  vbyte;
    int errs;
    errs = err_cnt;
    base  = 14'($urandom);
    vbyte = 8'($urandom);
    send_vram_cmd(OP_VRAM_WRITE, base);
    bus_write(DATA_PORT, vbyte);
    send_vram_cmd(OP_VRAM_READ, base);
    bus_read(DATA_PORT, vbyte);
    send_reg_write(4'd7, 8'($urandom));  // Lands while still in read data phase
    check_equal(vdp_regs, exp_regs, "register write during read data phase");
    report_test("cmd_restart", errs);
  endtask

  initial begin
    rst_L     = 1'b0;
    addr      = 8'h00;
    data_in   = 8'h00;
    iorq_L    = 1'b1;
    rd_L      = 1'b1;
    wr_L      = 1'b1;
    exp_regs  = '0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    void'($urandom(RAND_SEED));
    repeat (16) @(posedge clk);
    #1;
    rst_L = 1'b1;
    step_cycle();

    test_reset_state();
    test_reg_writes();
    write_then_read("seq_write_read", 14'($urandom), 8);
    write_then_read("addr_wrap", 14'd16382, 4);
    test_cram_write();
    test_cmd_restart();

    $display("Tests run %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- vlog.f
vdp_pkg.sv
vdp_port_decoder.sv
vdp_cmd_ctrl.sv
vdp_vram.sv
vdp_reg_file.sv
vdp_read_port.sv
vdp_top.sv
tb_vdp_top.sv

//--- Bender.yml
package:
  name: vdp

sources:
  - vdp_pkg.sv
  - vdp_port_decoder.sv
  - vdp_cmd_ctrl.sv
  - vdp_vram.sv
  - vdp_reg_file.sv
  - vdp_read_port.sv
  - vdp_top.sv
  - target: test
    files:
      - tb_vdp_top.sv
